// File: design/elevator_pkg.sv
// Elevator request types
package elevator_pkg;

    //////////////////////////////////////////////////
    // Floor limits and vectors
    //////////////////////////////////////////////////

    // Largest building the types can describe
    localparam int max_floors = 16;

    // Floor index, floor 1 is 0
    typedef logic [$clog2(max_floors)-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [max_floors-1:0] floor_mask_t;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // Status reported by the motion controller
    typedef struct packed {
        floor_t floor;
        logic   moving;
        logic   power_on;
        logic   emergency;
    } car_status_t;

    // Per floor command from the decoder
    typedef struct packed {
        logic panel_press;
        logic call_press;
        logic arrived;
    } floor_cmd_t;

    typedef struct packed {
        logic panel_light;
        logic call_light;
    } request_lights_t;

    // Command to the motion controller
    typedef struct packed {
        floor_t target;
        logic   direction_up;
        logic   activate;
    } dispatch_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_ctrl_t;

endpackage

// File: design/button_decoder.sv
// Button press decoder
`timescale 1ns/1ps

module button_decoder
    import elevator_pkg::*;
#(
    parameter int num_floors = 11
) (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  car_status_t car_status,
    output floor_cmd_t  floor_cmds [num_floors]
);

    // Previous samples of the served button bits
    logic [num_floors-1:0] call_prev;
    logic [num_floors-1:0] panel_prev;

    logic [num_floors-1:0] at_floor;
    logic [num_floors-1:0] call_new;
    logic [num_floors-1:0] panel_new;
    logic                  accept_press;
    logic                  car_parked;

    //////////////////////////////////////////////////
    // Gating
    //////////////////////////////////////////////////

    // Presses only count with power on and no emergency
    assign accept_press = car_status.power_on && !car_status.emergency;

    // Stopped and powered, so the car is serving its floor
    assign car_parked = !car_status.moving && car_status.power_on;

    // One-hot decode of the car position
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            at_floor[i] = (car_status.floor == floor_t'(i));
        end
    end

    // Rising edges, minus the floor the car stands at
    assign call_new = floor_call_buttons[num_floors-1:0] & ~call_prev & ~at_floor
                      & {num_floors{accept_press}};
    assign panel_new = panel_buttons[num_floors-1:0] & ~panel_prev & ~at_floor
                       & {num_floors{accept_press}};

    //////////////////////////////////////////////////
    // Command registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_prev  <= '0;
            panel_prev <= '0;
            for (int i = 0; i < num_floors; i++) begin
                floor_cmds[i] <= '0;
            end
        end else begin
            call_prev  <= floor_call_buttons[num_floors-1:0];
            panel_prev <= panel_buttons[num_floors-1:0];
            for (int i = 0; i < num_floors; i++) begin
                floor_cmds[i].panel_press <= panel_new[i];
                floor_cmds[i].call_press  <= call_new[i];
                floor_cmds[i].arrived     <= at_floor[i] && car_parked;
            end
        end
    end

endmodule

// File: design/floor_request_latch.sv
// Floor request lights
`timescale 1ns/1ps

module floor_request_latch
    import elevator_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,
    input  floor_cmd_t      cmd,
    output request_lights_t lights
);

    // Arrival wins, though the decoder never sends a press with it
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (cmd.arrived) begin
            lights <= '0;
        end else begin
            if (cmd.panel_press) begin
                lights.panel_light <= 1'b1;
            end
            if (cmd.call_press) begin
                lights.call_light <= 1'b1;
            end
        end
    end

endmodule

// File: design/car_dispatcher.sv
// Car dispatcher
`timescale 1ns/1ps

module car_dispatcher
    import elevator_pkg::*;
#(
    parameter int num_floors = 11
) (
    input  logic            clock,
    input  logic            reset_n,
    input  request_lights_t lights [num_floors],
    input  car_status_t     car_status,
    input  logic            door_open_btn,
    input  logic            door_close_btn,
    output dispatch_t       dispatch,
    output door_ctrl_t      door_ctrl
);

    logic [num_floors-1:0] pending;
    floor_t                top_floor;
    logic                  any_pending;
    logic                  car_ready;
    logic                  doors_usable;

    //////////////////////////////////////////////////
    // Target selection
    //////////////////////////////////////////////////

    // A floor is pending if either of its lights is on
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            pending[i] = lights[i].panel_light || lights[i].call_light;
        end
    end

    assign any_pending = |pending;

    // Highest pending floor, else stay where the car is
    always_comb begin
        top_floor = car_status.floor;
        for (int i = 0; i < num_floors; i++) begin
            if (pending[i]) begin
                top_floor = floor_t'(i);
            end
        end
    end

    assign car_ready = !car_status.moving && car_status.power_on
                       && !car_status.emergency;

    // Emergency does not lock the doors, only motion or power loss
    assign doors_usable = !car_status.moving && car_status.power_on;

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dispatch  <= '0;
            door_ctrl <= '0;
        end else begin
            dispatch.target       <= top_floor;
            dispatch.direction_up <= (top_floor >= car_status.floor);
            dispatch.activate     <= any_pending && car_ready;

            door_ctrl.open_allowed  <= doors_usable && door_open_btn;
            door_ctrl.close_allowed <= doors_usable && door_close_btn;
        end
    end

endmodule

// File: design/elevator_requests_top.sv
// Elevator request side
`timescale 1ns/1ps

module elevator_requests_top
    import elevator_pkg::*;
#(
    parameter int num_floors = 11
) (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  car_status_t car_status,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output dispatch_t   dispatch,
    output door_ctrl_t  door_ctrl
);

    floor_cmd_t      floor_cmds [num_floors];
    request_lights_t lights     [num_floors];

    // Served floors only, widened below
    logic [num_floors-1:0] call_lit;
    logic [num_floors-1:0] panel_lit;

    button_decoder #(
        .num_floors(num_floors)
    ) u_button_decoder (
        .clock             (clock),
        .reset_n           (reset_n),
        .floor_call_buttons(floor_call_buttons),
        .panel_buttons     (panel_buttons),
        .car_status        (car_status),
        .floor_cmds        (floor_cmds)
    );

    //////////////////////////////////////////////////
    // One latch per floor
    //////////////////////////////////////////////////

    for (genvar i = 0; i < num_floors; i++) begin : gen_floor
        floor_request_latch u_floor_request_latch (
            .clock  (clock),
            .reset_n(reset_n),
            .cmd    (floor_cmds[i]),
            .lights (lights[i])
        );

        assign call_lit[i]  = lights[i].call_light;
        assign panel_lit[i] = lights[i].panel_light;
    end

    // Zero extension ties the unused upper floors low
    assign call_button_lights  = floor_mask_t'(call_lit);
    assign panel_button_lights = floor_mask_t'(panel_lit);

    car_dispatcher #(
        .num_floors(num_floors)
    ) u_car_dispatcher (
        .clock         (clock),
        .reset_n       (reset_n),
        .lights        (lights),
        .car_status    (car_status),
        .door_open_btn (door_open_btn),
        .door_close_btn(door_close_btn),
        .dispatch      (dispatch),
        .door_ctrl     (door_ctrl)
    );

endmodule

// File: dv/elevator_requests_properties.sv
// Elevator request assertions
`timescale 1ns/1ps

module elevator_requests_properties
    import elevator_pkg::*;
#(
    parameter int num_floors = 11
) (
    input logic        clock,
    input logic        reset_n,
    input car_status_t car_status,
    input floor_mask_t call_button_lights,
    input floor_mask_t panel_button_lights,
    input dispatch_t   dispatch,
    input door_ctrl_t  door_ctrl
);

    // Activate is registered from the lights of the cycle before
    a_activate_needs_request: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(dispatch.activate) |-> $past((call_button_lights | panel_button_lights) != '0)
    ) else $error("activate rose with no request light on");

    a_no_activate_unsafe: assert property (@(posedge clock) disable iff (!reset_n)
        $past(car_status.moving || car_status.emergency) |-> !dispatch.activate
    ) else $error("activate high after the car was moving or in emergency");

    a_doors_locked_moving: assert property (@(posedge clock) disable iff (!reset_n)
        $past(car_status.moving) |-> door_ctrl == '0
    ) else $error("door permission given after the car was moving");

    // Floors above the building stay dark
    a_upper_bits_zero: assert property (@(posedge clock) disable iff (!reset_n)
        ((call_button_lights | panel_button_lights) >> num_floors) == '0
    ) else $error("light set above the served floors");

endmodule

bind elevator_requests_top elevator_requests_properties #(
    .num_floors(num_floors)
) u_elevator_requests_properties (
    .clock              (clock),
    .reset_n            (reset_n),
    .car_status         (car_status),
    .call_button_lights (call_button_lights),
    .panel_button_lights(panel_button_lights),
    .dispatch           (dispatch),
    .door_ctrl          (door_ctrl)
);

// File: dv/elevator_requests_tb.sv
// Elevator request testbench
`timescale 1ns/1ps

module elevator_requests_tb
    import elevator_pkg::*;
();

    localparam int  num_floors   = 11;
    localparam time clock_period = 40;

    typedef struct packed {
        floor_mask_t call_btns;
        floor_mask_t panel_btns;
        logic [1:0]  doors;
        car_status_t status;
        logic [3:0]  hold;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
        dispatch_t   exp_dispatch;
        door_ctrl_t  exp_door;
    } stim_row_t;

    logic        clock = 1'b0;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    car_status_t car_status;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    dispatch_t   dispatch;
    door_ctrl_t  door_ctrl;

    // Reference model of the request lights
    stim_row_t   rows [$];
    floor_mask_t model_call;
    floor_mask_t model_panel;
    floor_mask_t prev_call;
    floor_mask_t prev_panel;
    logic [15:0] lfsr_state;
    int          error_count;

    always #(clock_period / 2) clock = ~clock;

    elevator_requests_top #(
        .num_floors(num_floors)
    ) u_elevator_requests_top (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .car_status         (car_status),
        .call_button_lights (call_button_lights),
        .panel_button_lights(panel_button_lights),
        .dispatch           (dispatch),
        .door_ctrl          (door_ctrl)
    );

    //////////////////////////////////////////////////
    // Failure reporting, waits and compares
    //////////////////////////////////////////////////

    task automatic report_failure(input string reason);
        error_count++;
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic wait_edges(input logic rising, input int count, input string what);
        int  seen;
        time limit;
        seen  = 0;
        limit = $time + time'(count + 1) * clock_period;
        while (seen < count) begin
            if (rising) begin
                @(posedge clock);
            end else begin
                @(negedge clock);
            end
            seen++;
            if ($time > limit) begin
                report_failure($sformatf("Timeout while waiting for %s", what));
            end
        end
    endtask

    task automatic check_mask(input string name, input floor_mask_t got, input floor_mask_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_dispatch(input dispatch_t got, input dispatch_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "Mismatch at %0t: dispatch got target %0d up %b act %b expected %0d %b %b",
                $time, got.target, got.direction_up, got.activate,
                exp.target, exp.direction_up, exp.activate));
        end
    endtask

    task automatic check_door(input door_ctrl_t got, input door_ctrl_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: door_ctrl got %b expected %b",
                                     $time, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_mask(output floor_mask_t mask);
        mask = '0;
        for (int i = 0; i < num_floors; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            mask[i]    = lfsr_state[0];
        end
    endtask

    // Flags are moving, power_on, emergency
    function automatic car_status_t make_status(input int level, input logic [2:0] flags);
        car_status_t status;
        status.floor = floor_t'(level);
        {status.moving, status.power_on, status.emergency} = flags;
        return status;
    endfunction

    task automatic add_row(input floor_mask_t call, input floor_mask_t panel,
                           input logic [1:0] doors, input car_status_t status, input int hold);
        stim_row_t   row;
        floor_mask_t served;
        floor_mask_t here;
        floor_mask_t pending;
        logic        parked;
        logic        found;
        served = floor_mask_t'((1 << num_floors) - 1);
        here   = floor_mask_t'(1) << status.floor;
        parked = !status.moving && status.power_on;
        // Rising presses count only with power on, no emergency, away from the car
        if (status.power_on && !status.emergency) begin
            model_call  |= call & ~prev_call & ~here & served;
            model_panel |= panel & ~prev_panel & ~here & served;
        end
        if (parked) begin
            model_call  &= ~here;
            model_panel &= ~here;
        end
        prev_call  = call;
        prev_panel = panel;
        pending    = model_call | model_panel;
        found      = 1'b0;
        row.exp_dispatch.target = status.floor;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (pending[i] && !found) begin
                row.exp_dispatch.target = floor_t'(i);
                found = 1'b1;
            end
        end
        row.exp_dispatch.direction_up = row.exp_dispatch.target >= status.floor;
        row.exp_dispatch.activate     = found && parked && !status.emergency;
        row.exp_door   = {parked && doors[1], parked && doors[0]};
        row.call_btns  = call;
        row.panel_btns = panel;
        row.doors      = doors;
        row.status     = status;
        row.hold       = 4'(hold);
        row.exp_call   = model_call;
        row.exp_panel  = model_panel;
        rows.push_back(row);
    endtask

    task automatic apply_row(input stim_row_t row);
        wait_edges(1'b1, 1, "the row start edge");
        floor_call_buttons <= row.call_btns;
        panel_buttons      <= row.panel_btns;
        {door_open_btn, door_close_btn} <= row.doors;
        car_status         <= row.status;
        wait_edges(1'b1, int'(row.hold), "the row hold time");
        wait_edges(1'b0, 1, "the sampling edge");
        check_mask("call_button_lights", call_button_lights, row.exp_call);
        check_mask("panel_button_lights", panel_button_lights, row.exp_panel);
        check_dispatch(dispatch, row.exp_dispatch);
        check_door(door_ctrl, row.exp_door);
    endtask

    initial begin
        floor_mask_t call_rand;
        floor_mask_t panel_rand;
        reset_n            <= 1'b0;
        floor_call_buttons <= '0;
        panel_buttons      <= '0;
        door_open_btn      <= 1'b0;
        door_close_btn     <= 1'b0;
        car_status         <= '0;
        model_call  = '0;
        model_panel = '0;
        prev_call   = '0;
        prev_panel  = '0;
        lfsr_state  = 16'd42031;
        error_count = 0;
        wait_edges(1'b1, 5, "reset release");
        reset_n <= 1'b1;
        wait_edges(1'b0, 1, "the first edge after reset");
        check_mask("call_button_lights", call_button_lights, '0);
        check_mask("panel_button_lights", panel_button_lights, '0);
        check_dispatch(dispatch, '0);
        check_door(door_ctrl, '0);

        // Car parked at floor 3, press at its own floor is dropped
        add_row(16'h0000, 16'h0000, 2'b00, make_status(2, 3'b010), 3);
        add_row(16'h0204, 16'h0120, 2'b00, make_status(2, 3'b010), 4);
        // Power off and emergency drop new presses
        add_row(16'h0000, 16'h0000, 2'b00, make_status(2, 3'b000), 3);
        add_row(16'h0008, 16'h0002, 2'b00, make_status(2, 3'b000), 3);
        add_row(16'h0000, 16'h0000, 2'b00, make_status(2, 3'b011), 3);
        add_row(16'h0400, 16'h0001, 2'b00, make_status(2, 3'b011), 3);
        // Arrivals, moving car and door permissions
        add_row(16'h0000, 16'h0000, 2'b10, make_status(5, 3'b110), 3);
        add_row(16'h0000, 16'h0000, 2'b10, make_status(5, 3'b010), 4);
        add_row(16'h0000, 16'h0000, 2'b01, make_status(9, 3'b010), 3);
        add_row(16'h0000, 16'h0000, 2'b01, make_status(8, 3'b110), 3);
        add_row(16'h0000, 16'h0000, 2'b00, make_status(8, 3'b010), 3);
        add_row(16'h0000, 16'h0000, 2'b11, make_status(8, 3'b000), 3);
        for (int n = 0; n < 8; n++) begin
            random_mask(call_rand);
            random_mask(panel_rand);
            add_row(call_rand, panel_rand, 2'b00, make_status(4, 3'b010), 3);
        end

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("One or more checks failed");
        end
    end

endmodule

// File: src.f
design/elevator_pkg.sv
design/button_decoder.sv
design/floor_request_latch.sv
design/car_dispatcher.sv
design/elevator_requests_top.sv
dv/elevator_requests_properties.sv
dv/elevator_requests_tb.sv

// File: Makefile
# Tool, flags, top module and file list
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := elevator_requests_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
